/* vector_unit.f */
hdl/pkg_vpu.sv
hdl/lane_regfile.sv
hdl/lane_alu.sv
hdl/lane_unit.sv
hdl/commit_agg_unit.sv
hdl/vector_unit.sv
dv/tb_vector_unit.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_vector_unit
FILELIST  = vector_unit.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_vector_unit.sv */
`timescale 1ns/1ps

module tb_vector_unit;

	import pkg_vpu::*;

	localparam int WAIT_LIMIT = 200;	// Cycles before a wait gives up

	logic		clock;
	logic		rst;
	logic		cmd_valid;
	opcode_t	cmd_op;
	reg_idx_t	cmd_dst;
	reg_idx_t	cmd_src1;
	reg_idx_t	cmd_src2;
	data_t		cmd_imm;
	issue_no_t	cmd_issue_no;
	v_ready_t	en_lane;
	data_t		scalar_in;
	lane_sel_t	scalar_sel;
	data_t		scalar_out;
	logic		commit_req;
	issue_no_t	commit_no;
	logic		commit_grant;
	logic		full;
	v_ready_t	status;

	data_t		shadow [NUM_LANES][NUM_REGS];	// Model register files
	data_t		model_last [NUM_LANES];
	issue_no_t	issue_q [$];	// Issued, not yet retired
	v_data_t	snap_q [$];		// Model last results right after each issue
	issue_no_t	next_issue;
	reg_idx_t	last_dst;
	int			checks;
	int			errors;
	int			err_mark;
	int			grant_max;		// Longest random grant delay
	logic		hold_grants;

	vector_unit vector_unit_i (
		.clock			(clock),
		.rst			(rst),
		.cmd_valid		(cmd_valid),
		.cmd_op			(cmd_op),
		.cmd_dst		(cmd_dst),
		.cmd_src1		(cmd_src1),
		.cmd_src2		(cmd_src2),
		.cmd_imm		(cmd_imm),
		.cmd_issue_no	(cmd_issue_no),
		.en_lane		(en_lane),
		.scalar_in		(scalar_in),
		.scalar_sel		(scalar_sel),
		.scalar_out		(scalar_out),
		.commit_req		(commit_req),
		.commit_no		(commit_no),
		.commit_grant	(commit_grant),
		.full			(full),
		.status			(status)
	);

	always #2 clock = ~clock;

	////////////////////
	// Reference model

	function automatic void ref_exec(input opcode_t op, input reg_idx_t dst, input reg_idx_t src1,
			input reg_idx_t src2, input data_t imm, input data_t scalar, input v_ready_t en);
		data_t a [NUM_LANES];
		data_t b [NUM_LANES];
		data_t res;
		for (int l = 0; l < NUM_LANES; l++) begin
			a[l] = shadow[l][src1];	// All reads before any write, for rotate
			b[l] = shadow[l][src2];
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			case (op)
				OP_ADD:		res = a[l] + b[l];
				OP_SUB:		res = a[l] - b[l];
				OP_AND:		res = a[l] & b[l];
				OP_XOR:		res = a[l] ^ b[l];
				OP_MUL:		res = a[l] * b[l];	// Low word only
				OP_ADDI:	res = a[l] + imm;
				OP_BCAST:	res = scalar;
				OP_ROT:		res = a[(l + 1) % NUM_LANES];
				default:	res = '0;
			endcase
			if (en[l]) begin
				shadow[l][dst] = res;
				model_last[l] = res;
			end
		end
	endfunction

	////////////////////
	// Helpers

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic tick();
		@(posedge clock);
		#0.5;
	endtask

	task automatic end_run();
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout while waiting for %0s after %0d cycles", what, WAIT_LIMIT);
		end_run();
	endtask

	task automatic finish_test(input string name);
		$display("Test %0s finished with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	task automatic sweep_lanes(input v_data_t exp);
		for (int l = 0; l < NUM_LANES; l++) begin
			scalar_sel = lane_sel_t'(l);
			#0.5;	// Combinational readout
			check(scalar_out, exp[l], $sformatf("last result of lane %0d", l));
		end
	endtask

	task automatic issue_cmd(input opcode_t op, input reg_idx_t dst, input reg_idx_t src1,
			input reg_idx_t src2, input data_t imm, input v_ready_t en);
		int n;
		v_data_t snap;
		data_t scalar;
		n = 0;
		while (full && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (full) begin
			report_timeout("space in the commit buffer");
		end else begin
			scalar = $urandom();
			cmd_valid = 1'b1;
			cmd_op = op;
			cmd_dst = dst;
			cmd_src1 = src1;
			cmd_src2 = src2;
			cmd_imm = imm;
			cmd_issue_no = next_issue;
			en_lane = en;
			scalar_in = scalar;
			ref_exec(op, dst, src1, src2, imm, scalar, en);
			for (int l = 0; l < NUM_LANES; l++) begin
				snap[l] = model_last[l];
			end
			issue_q.push_back(next_issue);
			snap_q.push_back(snap);
			next_issue++;
			last_dst = dst;
			tick();
			cmd_valid = 1'b0;
		end
	endtask

	// Half of the time source 1 is the previous destination
	task automatic issue_random(input int op_hi, input v_ready_t en);
		reg_idx_t src1;
		src1 = reg_idx_t'($urandom_range(0, NUM_REGS - 1));
		if ($urandom_range(0, 1) == 1) begin
			src1 = last_dst;
		end
		issue_cmd(opcode_t'(3'($urandom_range(0, op_hi))), reg_idx_t'($urandom_range(0, 7)),
			src1, reg_idx_t'($urandom_range(0, 7)), $urandom(), en);
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((issue_q.size() != 0 || status != '0) && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (issue_q.size() != 0 || status != '0) begin
			report_timeout("every instruction to retire");
		end else begin
			repeat (2) begin
				tick();
			end
		end
	endtask

	////////////////////
	// Commit compare

	task automatic grant_commit();
		v_data_t snap;
		commit_grant = 1'b1;
		if (issue_q.size() == 0) begin
			errors++;
			$display("Commit %0d arrived with no instruction outstanding", commit_no);
		end else begin
			check(32'(commit_no), 32'(issue_q[0]), "commit number");
			snap = snap_q[0];
			void'(issue_q.pop_front());
			void'(snap_q.pop_front());
			if (issue_q.size() == 0) begin
				sweep_lanes(snap);	// No later instruction has written back yet
			end
		end
		tick();
		commit_grant = 1'b0;
	endtask

	initial begin : commit_compare
		int delay;
		forever begin
			tick();
			if (commit_req && !hold_grants) begin
				delay = $urandom_range(0, grant_max);
				repeat (delay) begin
					tick();
				end
				grant_commit();
			end
		end
	end

	////////////////////
	// Stimulus

	initial begin : stimulus
		v_ready_t en;
		clock = 1'b0;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = OP_ADD;
		cmd_dst = '0;
		cmd_src1 = '0;
		cmd_src2 = '0;
		cmd_imm = '0;
		cmd_issue_no = '0;
		en_lane = '0;
		scalar_in = '0;
		scalar_sel = '0;
		commit_grant = 1'b0;
		checks = 0;
		errors = 0;
		err_mark = 0;
		grant_max = 2;
		hold_grants = 1'b0;
		next_issue = '0;
		last_dst = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			model_last[l] = '0;
			for (int r = 0; r < NUM_REGS; r++) begin
				shadow[l][r] = '0;
			end
		end
		void'($urandom(32'hf7fdbdfb));
		repeat (10) begin
			@(posedge clock);
		end
		#0.5;
		rst = 1'b0;

		check(32'(commit_req), 0, "commit_req after reset");
		check(32'(full), 0, "full after reset");
		check(32'(status), 0, "status after reset");
		sweep_lanes('0);
		tick();
		finish_test("reset state");

		// Distinct values per lane first
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				issue_cmd(OP_ADDI, reg_idx_t'(r), reg_idx_t'(r), '0, $urandom(),
					v_ready_t'(1 << l));
			end
		end
		repeat (40) begin
			issue_random(5, '1);
		end
		drain();
		finish_test("arithmetic");

		repeat (6) begin
			issue_cmd(OP_BCAST, reg_idx_t'($urandom_range(0, 7)), '0, '0, '0, '1);
			drain();	// Swept at its own commit
			issue_cmd(OP_ROT, reg_idx_t'($urandom_range(0, 7)),
				reg_idx_t'($urandom_range(0, 7)), '0, '0, '1);
			drain();
		end
		finish_test("broadcast and rotate");

		repeat (30) begin
			en = v_ready_t'($urandom_range(0, 15));
			if ($urandom_range(0, 4) == 0) begin
				en = '0;
			end
			issue_random(7, en);
		end
		issue_random(7, '0);
		drain();
		finish_test("lane enables");

		grant_max = 6;
		repeat (24) begin
			issue_random(7, v_ready_t'($urandom_range(0, 15)));
			repeat ($urandom_range(0, 2)) begin
				tick();
			end
		end
		drain();
		grant_max = 2;
		finish_test("commit order");

		hold_grants = 1'b1;
		repeat (BUFF_SIZE - 1) begin
			issue_random(7, '1);
		end
		check(32'(full), 0, "full before the buffer fills");
		issue_random(7, '1);
		check(32'(full), 1, "full with the buffer filled");
		check(32'(status), 32'(v_ready_t'('1)), "status with every lane busy");
		repeat (10) begin
			tick();
		end
		check(32'(full), 1, "full while grants are withheld");
		check(32'(commit_req), 1, "commit_req while grants are withheld");
		check(32'(commit_no), 32'(issue_q[0]), "held commit number");
		check(32'(status), 0, "status with the lanes idle");
		hold_grants = 1'b0;
		drain();
		check(32'(full), 0, "full after grants resume");
		finish_test("back-pressure");

		end_run();
	end

endmodule

/* hdl/vector_unit.sv */
`timescale 1ns/1ps

module vector_unit (
	input							clock,
	input							rst,
	input							cmd_valid,		// One-cycle command strobe
	input	pkg_vpu::opcode_t		cmd_op,
	input	pkg_vpu::reg_idx_t		cmd_dst,
	input	pkg_vpu::reg_idx_t		cmd_src1,
	input	pkg_vpu::reg_idx_t		cmd_src2,
	input	pkg_vpu::data_t			cmd_imm,
	input	pkg_vpu::issue_no_t		cmd_issue_no,
	input	pkg_vpu::v_ready_t		en_lane,		// Lanes that run this command
	input	pkg_vpu::data_t			scalar_in,		// Broadcast source
	input	pkg_vpu::lane_sel_t		scalar_sel,
	output	pkg_vpu::data_t			scalar_out,		// Last result of selected lane
	output	logic					commit_req,
	output	pkg_vpu::issue_no_t		commit_no,
	input							commit_grant,
	output	logic					full,
	output	pkg_vpu::v_ready_t		status
);

	import pkg_vpu::*;

	v_data_t						src1_bus;		// Neighbour operand bus
	v_data_t						last_results;
	v_ready_t						lane_commit;
	issue_no_t [NUM_LANES-1:0]		lane_commit_no;
	logic							cmd_accept;		// Strobe while full is dropped

	assign scalar_out = last_results[scalar_sel];
	assign cmd_accept = cmd_valid && !full;

	////////////////////
	// Lane array

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lane_unit #(
			.LANE_ID		(i)
		) lane_unit_i (
			.clock			(clock),
			.rst			(rst),
			.cmd_valid		(cmd_accept),
			.en				(en_lane[i]),
			.cmd_op			(cmd_op),
			.cmd_dst		(cmd_dst),
			.cmd_src1		(cmd_src1),
			.cmd_src2		(cmd_src2),
			.cmd_imm		(cmd_imm),
			.scalar_in		(scalar_in),
			.cmd_issue_no	(cmd_issue_no),
			.neighbour_bus	(src1_bus),
			.src1_out		(src1_bus[i]),
			.last_result	(last_results[i]),
			.commit			(lane_commit[i]),
			.commit_no		(lane_commit_no[i]),
			.status			(status[i])
		);
	end

	////////////////////
	// Commit aggregation

	commit_agg_unit commit_agg_unit_i (
		.clock			(clock),
		.rst			(rst),
		.req			(cmd_valid),
		.issue_no		(cmd_issue_no),
		.en_lane		(en_lane),
		.lane_commit	(lane_commit),
		.lane_commit_no	(lane_commit_no),
		.commit_req		(commit_req),
		.commit_no		(commit_no),
		.commit_grant	(commit_grant),
		.full			(full)
	);

endmodule

/* hdl/commit_agg_unit.sv */
`timescale 1ns/1ps

module commit_agg_unit (
	input											clock,
	input											rst,
	input											req,			// Command strobe
	input	pkg_vpu::issue_no_t						issue_no,
	input	pkg_vpu::v_ready_t						en_lane,		// Lanes expected to finish
	input	pkg_vpu::v_ready_t						lane_commit,	// Per-lane done pulses
	input	pkg_vpu::issue_no_t [pkg_vpu::NUM_LANES-1:0]	lane_commit_no,
	output	logic									commit_req,
	output	pkg_vpu::issue_no_t						commit_no,
	input											commit_grant,
	output	logic									full
);

	import pkg_vpu::*;

	issue_no_t					buf_issue [BUFF_SIZE];
	v_ready_t					buf_mask [BUFF_SIZE];
	v_ready_t					buf_done [BUFF_SIZE];
	v_ready_t					done_next [BUFF_SIZE];
	logic [BUFF_SIZE-1:0]		buf_valid;

	logic [BUFF_PTR_W-1:0]		head;
	logic [BUFF_PTR_W-1:0]		tail;
	logic [BUFF_PTR_W:0]		count;

	agg_state_t					state;
	logic						alloc;
	logic						pop;
	logic						head_complete;

	assign full		= (count == (BUFF_PTR_W + 1)'(BUFF_SIZE));
	assign alloc	= req && !full;					// Strobe while full is dropped
	assign pop		= (state == WAIT_GRANT) && commit_grant;

	////////////////////
	// Lane completions

	// Pulses merged in the same cycle so a finished head is seen at once
	always_comb begin
		for (int e = 0; e < BUFF_SIZE; e++) begin
			done_next[e] = buf_done[e];
			for (int l = 0; l < NUM_LANES; l++) begin
				if (buf_valid[e] && lane_commit[l] && (buf_issue[e] == lane_commit_no[l])) begin
					done_next[e][l] = 1'b1;
				end
			end
		end
	end

	assign head_complete = buf_valid[head] && (done_next[head] == buf_mask[head]);

	always_ff @(posedge clock) begin
		for (int e = 0; e < BUFF_SIZE; e++) begin
			buf_done[e] <= done_next[e];
		end
		if (alloc) begin
			buf_issue[tail]	<= issue_no;
			buf_mask[tail]	<= en_lane;
			buf_done[tail]	<= '0;					// New entry starts clean
		end
	end

	////////////////////
	// Pointers

	always_ff @(posedge clock) begin
		if (rst) begin
			head		<= '0;
			tail		<= '0;
			count		<= '0;
			buf_valid	<= '0;
		end else begin
			if (alloc) begin
				buf_valid[tail]	<= 1'b1;
				tail			<= tail + 1'b1;
			end
			if (pop) begin
				buf_valid[head]	<= 1'b0;
				head			<= head + 1'b1;
			end
			case ({alloc, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	////////////////////
	// Commit presenter

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:		if (head_complete) state <= WAIT_GRANT;
				WAIT_GRANT:	if (commit_grant) state <= IDLE;
				default:	state <= IDLE;
			endcase
		end
	end

	assign commit_req	= (state == WAIT_GRANT);
	assign commit_no	= buf_issue[head];			// Stable until the grant pops it

endmodule

/* hdl/lane_unit.sv */
`timescale 1ns/1ps

module lane_unit #(
	parameter int LANE_ID = 0
) (
	input							clock,
	input							rst,
	input							cmd_valid,		// One-cycle command strobe
	input							en,				// Lane enable for this command
	input	pkg_vpu::opcode_t		cmd_op,
	input	pkg_vpu::reg_idx_t		cmd_dst,
	input	pkg_vpu::reg_idx_t		cmd_src1,
	input	pkg_vpu::reg_idx_t		cmd_src2,
	input	pkg_vpu::data_t			cmd_imm,
	input	pkg_vpu::data_t			scalar_in,
	input	pkg_vpu::issue_no_t		cmd_issue_no,
	input	pkg_vpu::v_data_t		neighbour_bus,	// Source 1 of every lane
	output	pkg_vpu::data_t			src1_out,
	output	pkg_vpu::data_t			last_result,
	output	logic					commit,			// Pulse after write-back
	output	pkg_vpu::issue_no_t		commit_no,
	output	logic					status
);

	import pkg_vpu::*;

	data_t			rd_a;
	data_t			rd_b;
	data_t			alu_result;

	logic			op_valid;		// Operand stage holds an enabled command
	opcode_t		op_code;
	reg_idx_t		op_dst;
	data_t			op_a;
	data_t			op_b;
	data_t			op_imm;
	data_t			op_scalar;
	issue_no_t		op_issue_no;

	lane_regfile lane_regfile_i (
		.clock		(clock),
		.rst		(rst),
		.rd_idx_a	(cmd_src1),
		.rd_idx_b	(cmd_src2),
		.rd_data_a	(rd_a),
		.rd_data_b	(rd_b),
		.wr_en		(op_valid),
		.wr_idx		(op_dst),
		.wr_data	(alu_result)
	);

	////////////////////
	// Operand stage

	always_ff @(posedge clock) begin
		if (rst) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= cmd_valid && en;
		end
	end

	// Payload follows every command, so a neighbour's rotate still
	// reads this lane's fresh source 1 when this lane is disabled
	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			op_code		<= cmd_op;
			op_dst		<= cmd_dst;
			op_a		<= rd_a;
			op_b		<= rd_b;
			op_imm		<= cmd_imm;
			op_scalar	<= scalar_in;
			op_issue_no	<= cmd_issue_no;
		end
	end

	assign src1_out = op_a;

	////////////////////
	// Execute and write-back

	lane_alu lane_alu_i (
		.op			(op_code),
		.a			(op_a),
		.b			(op_b),
		.imm		(op_imm),
		.scalar		(op_scalar),
		.neighbour	(neighbour_bus[(LANE_ID + 1) % NUM_LANES]),
		.result		(alu_result)
	);

	always_ff @(posedge clock) begin
		if (rst) begin
			commit		<= 1'b0;
			last_result	<= '0;
		end else begin
			commit <= op_valid;
			if (op_valid) begin
				last_result <= alu_result;	// Kept for scalar readout
			end
		end
	end

	always_ff @(posedge clock) begin
		if (op_valid) begin
			commit_no <= op_issue_no;
		end
	end

	// Busy while an instruction sits in either stage
	assign status = op_valid || commit;

endmodule

/* hdl/lane_alu.sv */
`timescale 1ns/1ps

module lane_alu (
	input	pkg_vpu::opcode_t		op,
	input	pkg_vpu::data_t			a,			// Source 1 operand
	input	pkg_vpu::data_t			b,			// Source 2 operand
	input	pkg_vpu::data_t			imm,
	input	pkg_vpu::data_t			scalar,		// Broadcast value
	input	pkg_vpu::data_t			neighbour,	// Source 1 of next lane
	output	pkg_vpu::data_t			result
);

	import pkg_vpu::*;

	logic [2*DATA_W-1:0]	product;

	// Full product, only the low word is kept
	assign product = a * b;

	////////////////////
	// Result select

	always_comb begin
		case (op)
			OP_ADD: begin
				result = a + b;
			end
			OP_SUB: begin
				result = a - b;
			end
			OP_AND: begin
				result = a & b;
			end
			OP_XOR: begin
				result = a ^ b;
			end
			OP_MUL: begin
				result = product[DATA_W-1:0];	// Wraps like the adders
			end
			OP_ADDI: begin
				result = a + imm;
			end
			OP_BCAST: begin
				result = scalar;
			end
			OP_ROT: begin
				result = neighbour;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* hdl/lane_regfile.sv */
`timescale 1ns/1ps

module lane_regfile (
	input							clock,
	input							rst,
	input	pkg_vpu::reg_idx_t		rd_idx_a,	// Source 1 index
	input	pkg_vpu::reg_idx_t		rd_idx_b,	// Source 2 index
	output	pkg_vpu::data_t			rd_data_a,
	output	pkg_vpu::data_t			rd_data_b,
	input							wr_en,		// Write-back strobe
	input	pkg_vpu::reg_idx_t		wr_idx,
	input	pkg_vpu::data_t			wr_data
);

	import pkg_vpu::*;

	data_t		regs [NUM_REGS];

	////////////////////
	// Write port

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	////////////////////
	// Read ports

	// A write in the same cycle wins, so the next instruction sees it
	always_comb begin
		if (wr_en && (wr_idx == rd_idx_a)) begin
			rd_data_a = wr_data;	// Bypass from write-back
		end else begin
			rd_data_a = regs[rd_idx_a];
		end

		if (wr_en && (wr_idx == rd_idx_b)) begin
			rd_data_b = wr_data;	// Bypass from write-back
		end else begin
			rd_data_b = regs[rd_idx_b];
		end
	end

endmodule

/* hdl/pkg_vpu.sv */
package pkg_vpu;

	////////////////////
	// Sizes

	localparam int NUM_LANES	= 4;	// Lanes in the vector unit
	localparam int NUM_REGS		= 8;	// Registers per lane
	localparam int BUFF_SIZE	= 4;	// Commit buffer depth
	localparam int DATA_W		= 32;	// Lane datum width

	localparam int REG_IDX_W	= $clog2(NUM_REGS);
	localparam int ISSUE_NO_W	= 4;	// Wraps after 16 issues
	localparam int LANE_SEL_W	= $clog2(NUM_LANES);
	localparam int BUFF_PTR_W	= $clog2(BUFF_SIZE);	// Head and tail pointers

	////////////////////
	// Scalar types

	typedef logic [DATA_W-1:0]		data_t;
	typedef logic [REG_IDX_W-1:0]	reg_idx_t;
	typedef logic [ISSUE_NO_W-1:0]	issue_no_t;
	typedef logic [LANE_SEL_W-1:0]	lane_sel_t;

	////////////////////
	// Vector types

	// One bit per lane, used for enables, status and commit pulses
	typedef logic [NUM_LANES-1:0]	v_ready_t;

	// One datum per lane
	typedef data_t [NUM_LANES-1:0]	v_data_t;

	////////////////////
	// Command encoding

	typedef enum logic [2:0] {
		OP_ADD		= 3'd0,	// a + b
		OP_SUB		= 3'd1,	// a - b
		OP_AND		= 3'd2,	// a & b
		OP_XOR		= 3'd3,	// a ^ b
		OP_MUL		= 3'd4,	// Low word of a * b
		OP_ADDI		= 3'd5,	// a + imm
		OP_BCAST	= 3'd6,	// Scalar port value
		OP_ROT		= 3'd7	// Source-1 of next lane
	} opcode_t;

	////////////////////
	// Commit presenter

	typedef enum logic {
		IDLE		= 1'b0,	// Waiting for a complete head
		WAIT_GRANT	= 1'b1	// Request held until grant
	} agg_state_t;

endpackage
